// ==== source/memSysPkg.sv ====
// Assumes a 32-bit byte-addressed bus with 4-byte little-endian words and sizes up to a word
package memSysPkg;

  // Bytes per bus word, used for address to index arithmetic
  localparam int wordBytes = 4;

  // Byte address as seen by the core and the bus
  typedef logic [31:0] addrT;

  // One bus or core data word
  typedef logic [31:0] dataT;

  // Core byte enables, bit 0 is the lowest byte lane
  // Only contiguous aligned masks are expected: single bytes, 0011, 1100, 1111
  typedef logic [3:0] byteMaskT;

  // Bus transfer size, AHB style encoding
  typedef enum logic [2:0]
  {
    sizeByte = 3'b000,
    sizeHalf = 3'b001,
    sizeWord = 3'b010
  } hSizeT;

endpackage

// ==== source/instrCache.sv ====
// Direct-mapped I-cache; numLines and blockWords must be powers of two, blockWords at least 2
`timescale 1ns/1ps

module instrCache
  import memSysPkg::*;
#(
  parameter int numLines   = 16,
  parameter int blockWords = 4
) (
  input  logic clk,
  input  logic arstN,
  input  logic enable,
  input  logic invalidate,
  input  addrT pcF,
  output dataT instrF,
  output logic iStall,
  output logic instrRequest,
  output addrT instrAddr,
  input  logic instrReady,
  input  dataT instrRData
);

  localparam int offBits  = $clog2(wordBytes);
  localparam int wordBits = $clog2(blockWords);
  localparam int idxBits  = $clog2(numLines);
  localparam int tagBits  = 32 - idxBits - wordBits - offBits;
  localparam logic [wordBits-1:0] lastWord = wordBits'(blockWords - 1);

  dataT                lineData [numLines][blockWords];
  logic [tagBits-1:0]  tagArr [numLines];
  logic [numLines-1:0] validArr;

  logic [wordBits-1:0] wordCnt;
  logic                pending;
  logic                modeQ;
  addrT                addrQ;
  addrT                curAddr;
  logic                hit;
  logic                refillAck;
  logic                refillDone;

  // Fields of the fetch address
  logic [tagBits-1:0]  pcTag;
  logic [idxBits-1:0]  pcIdx;
  logic [wordBits-1:0] pcWord;

  // Fields of the transfer in flight
  logic [tagBits-1:0]  tagQ;
  logic [idxBits-1:0]  idxQ;
  logic [wordBits-1:0] wordQ;

  assign pcTag  = pcF[31 -: tagBits];
  assign pcIdx  = pcF[offBits + wordBits +: idxBits];
  assign pcWord = pcF[offBits +: wordBits];

  assign tagQ  = addrQ[31 -: tagBits];
  assign idxQ  = addrQ[offBits + wordBits +: idxBits];
  assign wordQ = addrQ[offBits +: wordBits];

  assign hit = enable && validArr[pcIdx] && (tagArr[pcIdx] == pcTag);

  // Refill walks the aligned block, bypass reads the fetched word itself
  assign curAddr = enable ? {pcTag, pcIdx, wordCnt, {offBits{1'b0}}}
                          : {pcF[31:offBits], {offBits{1'b0}}};

  // Fields stay frozen while a transfer is outstanding
  assign instrRequest = pending || !hit;
  assign instrAddr    = pending ? addrQ : curAddr;

  assign refillAck  = instrReady && modeQ;
  assign refillDone = refillAck && (wordQ == lastWord);

  assign instrF = enable ? lineData[pcIdx][pcWord] : instrRData;
  assign iStall = enable ? !hit : !(instrReady && !modeQ);

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      pending  <= 1'b0;
      modeQ    <= 1'b0;
      wordCnt  <= '0;
      validArr <= '0;
    end
    else
    begin
      pending <= instrRequest && !instrReady;
      if (!pending)
      begin
        modeQ <= enable;
      end
      // Restart the block walk whenever no refill is wanted
      if (invalidate || !enable || hit)
      begin
        wordCnt <= '0;
      end
      else if (refillAck)
      begin
        wordCnt <= wordCnt + 1'b1;
      end
      // Invalidate wins over a line completing
      if (invalidate)
      begin
        validArr <= '0;
      end
      else if (refillDone)
      begin
        validArr[idxQ] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!pending)
    begin
      addrQ <= curAddr;
    end
    if (refillAck)
    begin
      lineData[idxQ][wordQ] <= instrRData;
    end
    if (refillDone)
    begin
      tagArr[idxQ] <= tagQ;
    end
  end

endmodule

// ==== source/dataPort.sv ====
// Uncached load/store port; expects contiguous aligned byte masks, loads are zero-extended
`timescale 1ns/1ps

module dataPort
  import memSysPkg::*;
(
  input  logic     clk,
  input  logic     arstN,
  input  logic     memRead,
  input  logic     memWrite,
  input  addrT     dataAdr,
  input  dataT     writeData,
  input  byteMaskT byteMask,
  output dataT     readData,
  output logic     dStall,
  output logic     dataRequest,
  output addrT     dataAddr,
  output logic     dataWrite,
  output dataT     dataWData,
  output hSizeT    dataSize,
  input  logic     dataReady,
  input  dataT     dataRData
);

  logic       access;
  logic       done;
  logic [1:0] laneOff;
  dataT       shifted;

  assign access = memRead || memWrite;

  // Block a repeat transfer while the core still holds the finished access
  assign dataRequest = access && !done;
  assign dStall      = access && !dataReady;

  // Lowest enabled lane gives the byte offset
  assign laneOff = byteMask[0] ? 2'd0 :
                   byteMask[1] ? 2'd1 :
                   byteMask[2] ? 2'd2 : 2'd3;

  always_comb
  begin
    case (byteMask)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: dataSize = sizeByte;
      4'b0011, 4'b1100:                   dataSize = sizeHalf;
      default:                            dataSize = sizeWord;
    endcase
  end

  assign dataAddr  = {dataAdr[31:2], laneOff};
  assign dataWrite = memWrite;
  // Core already places store bytes in their lanes
  assign dataWData = writeData;

  // Move addressed bytes down to bit 0
  assign shifted = dataRData >> {laneOff, 3'b000};

  always_comb
  begin
    case (dataSize)
      sizeByte: readData = {24'h0, shifted[7:0]};
      sizeHalf: readData = {16'h0, shifted[15:0]};
      default:  readData = shifted;
    endcase
  end

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      done <= 1'b0;
    end
    else
    begin
      done <= dataReady;
    end
  end

endmodule

// ==== source/busArbiter.sv ====
// Two-way bus arbiter with fixed data priority; one transfer in flight, requests held until ready
`timescale 1ns/1ps

module busArbiter
  import memSysPkg::*;
(
  input  logic  clk,
  input  logic  arstN,
  input  logic  instrRequest,
  input  addrT  instrAddr,
  output logic  instrReady,
  output dataT  instrRData,
  input  logic  dataRequest,
  input  addrT  dataAddr,
  input  logic  dataWrite,
  input  dataT  dataWData,
  input  hSizeT dataSize,
  output logic  dataReady,
  output dataT  dataRData,
  output logic  busRequest,
  output addrT  busAddr,
  output logic  busWrite,
  output dataT  busWData,
  output hSizeT busSize,
  input  logic  busReady,
  input  dataT  busRData
);

  logic busy;
  // High when the data side owns the bus
  logic ownerData;

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      busy      <= 1'b0;
      ownerData <= 1'b0;
    end
    else if (!busy)
    begin
      if (dataRequest)
      begin
        busy      <= 1'b1;
        ownerData <= 1'b1;
      end
      else if (instrRequest)
      begin
        busy      <= 1'b1;
        ownerData <= 1'b0;
      end
    end
    else if (busReady)
    begin
      busy <= 1'b0;
    end
  end

  assign busRequest = busy;

  // Owner fields onto the bus, fetches are word reads
  assign busAddr  = ownerData ? dataAddr : instrAddr;
  assign busWrite = ownerData && dataWrite;
  assign busWData = ownerData ? dataWData : '0;
  assign busSize  = ownerData ? dataSize : sizeWord;

  // Response goes back to the owner only
  assign dataReady  = busy && busReady && ownerData;
  assign instrReady = busy && busReady && !ownerData;
  assign dataRData  = ownerData ? busRData : '0;
  assign instrRData = ownerData ? '0 : busRData;

endmodule

// ==== source/busMemory.sv ====
// Bus memory slave; memWords must be a power of two, addresses wrap, contents start at zero
`timescale 1ns/1ps

module busMemory
  import memSysPkg::*;
#(
  parameter int memWords   = 256,
  parameter int waitStates = 1
) (
  input  logic  clk,
  input  logic  arstN,
  input  logic  busRequest,
  input  addrT  busAddr,
  input  logic  busWrite,
  input  dataT  busWData,
  input  hSizeT busSize,
  output logic  busReady,
  output dataT  busRData
);

  localparam int offBits = $clog2(wordBytes);
  localparam int idxBits = $clog2(memWords);
  localparam int cntBits = (waitStates > 0) ? $clog2(waitStates + 1) : 1;

  dataT memArr [memWords] = '{default: '0};

  logic                busy;
  logic [cntBits-1:0]  waitCnt;
  logic                accept;
  logic [idxBits-1:0]  wordIdx;
  logic [idxBits-1:0]  rdIdx;
  logic [wordBytes-1:0] writeLanes;

  assign accept  = busRequest && !busy;
  assign wordIdx = busAddr[offBits +: idxBits];

  // Lanes touched by the transfer
  always_comb
  begin
    case (busSize)
      sizeByte: writeLanes = 4'b0001 << busAddr[1:0];
      sizeHalf: writeLanes = 4'b0011 << {busAddr[1], 1'b0};
      default:  writeLanes = 4'b1111;
    endcase
  end

  // Ready comes waitStates+1 cycles after accept
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      busy    <= 1'b0;
      waitCnt <= '0;
    end
    else if (accept)
    begin
      busy    <= 1'b1;
      waitCnt <= cntBits'(waitStates);
    end
    else if (busy)
    begin
      if (waitCnt == '0)
      begin
        busy <= 1'b0;
      end
      else
      begin
        waitCnt <= waitCnt - 1'b1;
      end
    end
  end

  assign busReady = busy && (waitCnt == '0);

  // Writes land at accept, reads use the latched word
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      rdIdx <= wordIdx;
    end
    if (accept && busWrite)
    begin
      for (int i = 0; i < wordBytes; i++)
      begin
        if (writeLanes[i])
        begin
          memArr[wordIdx][8*i +: 8] <= busWData[8*i +: 8];
        end
      end
    end
  end

  assign busRData = memArr[rdIdx];

endmodule

// ==== source/memSubsystem.sv ====
// Single-clock memory subsystem; caller holds fetch and data inputs steady while stalled
`timescale 1ns/1ps

module memSubsystem
  import memSysPkg::*;
#(
  parameter int numLines   = 16,
  parameter int blockWords = 4,
  parameter int memWords   = 256,
  parameter int waitStates = 1
) (
  input  logic     clk,
  input  logic     arstN,
  input  logic     icEnable,
  input  logic     icInvalidate,
  input  addrT     pcF,
  output dataT     instrF,
  output logic     iStall,
  input  logic     memRead,
  input  logic     memWrite,
  input  addrT     dataAdr,
  input  dataT     writeData,
  input  byteMaskT byteMask,
  output dataT     readData,
  output logic     dStall
);

  // Instruction requester
  logic  instrRequest;
  logic  instrReady;
  addrT  instrAddr;
  dataT  instrRData;

  // Data requester
  logic  dataRequest;
  logic  dataReady;
  logic  dataWrite;
  addrT  dataAddr;
  dataT  dataWData;
  dataT  dataRData;
  hSizeT dataSize;

  // Shared bus
  logic  busRequest;
  logic  busReady;
  logic  busWrite;
  addrT  busAddr;
  dataT  busWData;
  dataT  busRData;
  hSizeT busSize;

  instrCache #(
    .numLines  (numLines  ),
    .blockWords(blockWords)
  ) instrCache_i (
    .clk         (clk         ),
    .arstN       (arstN       ),
    .enable      (icEnable    ),
    .invalidate  (icInvalidate),
    .pcF         (pcF         ),
    .instrF      (instrF      ),
    .iStall      (iStall      ),
    .instrRequest(instrRequest),
    .instrAddr   (instrAddr   ),
    .instrReady  (instrReady  ),
    .instrRData  (instrRData  )
  );

  dataPort dataPort_i (
    .clk        (clk        ),
    .arstN      (arstN      ),
    .memRead    (memRead    ),
    .memWrite   (memWrite   ),
    .dataAdr    (dataAdr    ),
    .writeData  (writeData  ),
    .byteMask   (byteMask   ),
    .readData   (readData   ),
    .dStall     (dStall     ),
    .dataRequest(dataRequest),
    .dataAddr   (dataAddr   ),
    .dataWrite  (dataWrite  ),
    .dataWData  (dataWData  ),
    .dataSize   (dataSize   ),
    .dataReady  (dataReady  ),
    .dataRData  (dataRData  )
  );

  busArbiter busArbiter_i (
    .clk         (clk         ),
    .arstN       (arstN       ),
    .instrRequest(instrRequest),
    .instrAddr   (instrAddr   ),
    .instrReady  (instrReady  ),
    .instrRData  (instrRData  ),
    .dataRequest (dataRequest ),
    .dataAddr    (dataAddr    ),
    .dataWrite   (dataWrite   ),
    .dataWData   (dataWData   ),
    .dataSize    (dataSize    ),
    .dataReady   (dataReady   ),
    .dataRData   (dataRData   ),
    .busRequest  (busRequest  ),
    .busAddr     (busAddr     ),
    .busWrite    (busWrite    ),
    .busWData    (busWData    ),
    .busSize     (busSize     ),
    .busReady    (busReady    ),
    .busRData    (busRData    )
  );

  busMemory #(
    .memWords  (memWords  ),
    .waitStates(waitStates)
  ) busMemory_i (
    .clk       (clk       ),
    .arstN     (arstN     ),
    .busRequest(busRequest),
    .busAddr   (busAddr   ),
    .busWrite  (busWrite  ),
    .busWData  (busWData  ),
    .busSize   (busSize   ),
    .busReady  (busReady  ),
    .busRData  (busRData  )
  );

endmodule

// ==== verif/memSubsystemTb.sv ====
// Expects the default top level sizes (256-word memory) and a run from the project root
`timescale 1ns/1ps

module memSubsystemTb
  import memSysPkg::*;
();

  localparam int memWords    = 256;
  localparam int waitStates  = 1;
  localparam int maxWait     = 100;
  localparam int scratchBase = 'h300;

  logic     clk;
  logic     arstN;
  logic     icEnable;
  logic     icInvalidate;
  addrT     pcF;
  dataT     instrF;
  logic     iStall;
  logic     memRead;
  logic     memWrite;
  addrT     dataAdr;
  dataT     writeData;
  byteMaskT byteMask;
  dataT     readData;
  logic     dStall;

  // Golden records with one entry per line of the file
  logic [31:0] recTest [$];
  logic [31:0] recOp [$];
  logic [31:0] recAddr [$];
  logic [31:0] recData [$];
  logic [31:0] recMask [$];
  logic [31:0] recExp [$];

  // Memory image kept by the same lane rules as the bus
  dataT        shadowMem [memWords];
  logic [31:0] rngState;
  int          errorCount;
  int          checkCount;
  int          testCount;
  logic        abortRun;

  memSubsystem #(
    .memWords  (memWords  ),
    .waitStates(waitStates)
  ) memSubsystem_i (
    .clk         (clk         ),
    .arstN       (arstN       ),
    .icEnable    (icEnable    ),
    .icInvalidate(icInvalidate),
    .pcF         (pcF         ),
    .instrF      (instrF      ),
    .iStall      (iStall      ),
    .memRead     (memRead     ),
    .memWrite    (memWrite    ),
    .dataAdr     (dataAdr     ),
    .writeData   (writeData   ),
    .byteMask    (byteMask    ),
    .readData    (readData    ),
    .dStall      (dStall      )
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #5 clk = ~clk;
    end
  end

  task automatic checkValue(input string name, input dataT got, input dataT expected);
    checkCount++;
    if (got !== expected)
    begin
      $display("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, expected);
      errorCount++;
    end
  endtask

  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rngState = x;
    return x;
  endfunction

  task automatic storeShadow(input addrT addr, input dataT data, input byteMaskT mask);
    int idx;
    idx = (addr >> 2) % memWords;
    for (int i = 0; i < 4; i++)
    begin
      if (mask[i])
      begin
        shadowMem[idx][8*i +: 8] = data[8*i +: 8];
      end
    end
  endtask

  // Enabled lanes packed down from bit 0 with the rest zero
  function automatic dataT expectLoad(input addrT addr, input byteMaskT mask);
    dataT word;
    dataT result;
    int   outByte;
    word    = shadowMem[(addr >> 2) % memWords];
    result  = '0;
    outByte = 0;
    for (int i = 0; i < 4; i++)
    begin
      if (mask[i])
      begin
        result[8*outByte +: 8] = word[8*i +: 8];
        outByte++;
      end
    end
    return result;
  endfunction

  task automatic readGolden();
    int               fd;
    int               n;
    logic [8*128-1:0] lineBuf;
    logic [31:0]      t;
    logic [31:0]      o;
    logic [31:0]      a;
    logic [31:0]      d;
    logic [31:0]      m;
    logic [31:0]      e;
    fd = $fopen("verif/memSubsystemGolden.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the golden file verif/memSubsystemGolden.txt");
      errorCount++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        lineBuf = '0;
        n = $fgets(lineBuf, fd);
        // Comment and blank lines do not yield six fields
        if (n > 0 && $sscanf(lineBuf, "%h %h %h %h %h %h", t, o, a, d, m, e) == 6)
        begin
          recTest.push_back(t);
          recOp.push_back(o);
          recAddr.push_back(a);
          recData.push_back(d);
          recMask.push_back(m);
          recExp.push_back(e);
        end
      end
      $fclose(fd);
    end
  endtask

  // Called 1 ns after a rising edge and returns at the same point of a later cycle
  task automatic dataAccess(input logic isWrite, input addrT addr, input dataT data,
                            input byteMaskT mask, output dataT result);
    int waited;
    waited    = 0;
    memRead   = !isWrite;
    memWrite  = isWrite;
    dataAdr   = addr;
    writeData = data;
    byteMask  = mask;
    @(negedge clk);
    while (dStall && waited < maxWait)
    begin
      @(negedge clk);
      waited++;
    end
    if (dStall)
    begin
      $display("Timeout: dStall never fell for the access at address %h", addr);
      errorCount++;
      abortRun = 1'b1;
    end
    else
    begin
      // A bus round trip takes at least the memory latency
      checkValue("dStall held for waitStates+1 cycles", {31'b0, waited > waitStates},
                 32'd1);
    end
    result = readData;
    @(posedge clk);
    #1;
    memRead  = 1'b0;
    memWrite = 1'b0;
  endtask

  task automatic fetchWord(input addrT addr, output dataT result, output logic firstStall);
    int waited;
    waited = 0;
    pcF    = addr;
    @(negedge clk);
    firstStall = iStall;
    while (iStall && waited < maxWait)
    begin
      @(negedge clk);
      waited++;
    end
    if (iStall)
    begin
      $display("Timeout: iStall never fell for the fetch at address %h", addr);
      errorCount++;
      abortRun = 1'b1;
    end
    result = instrF;
    @(posedge clk);
    #1;
  endtask

  // Lets the fetch already under way finish before pcF moves
  task automatic settleFetch(input string reason);
    int waited;
    waited = 0;
    @(negedge clk);
    while (iStall && waited < maxWait)
    begin
      @(negedge clk);
      waited++;
    end
    if (iStall)
    begin
      $display("Timeout: iStall never fell while %s", reason);
      errorCount++;
      abortRun = 1'b1;
    end
    @(posedge clk);
    #1;
  endtask

  // Data access raised next to a fetch in a scratch area away from code
  task automatic sideAccess(input addrT addr, input logic isWrite, input dataT data,
                            input int delay);
    dataT got;
    for (int i = 0; i < delay; i++)
    begin
      @(posedge clk);
      #1;
    end
    if (isWrite)
    begin
      storeShadow(addr, data, 4'hf);
      dataAccess(1'b1, addr, data, 4'hf, got);
      dataAccess(1'b0, addr, '0, 4'hf, got);
      checkValue("readData (side store read back)", got, expectLoad(addr, 4'hf));
    end
    else
    begin
      dataAccess(1'b0, addr, '0, 4'hf, got);
      checkValue("readData (side load)", got, expectLoad(addr, 4'hf));
    end
  endtask

  task automatic reportTest(input logic [31:0] num, input int errorsBefore);
    testCount++;
    if (errorCount == errorsBefore)
    begin
      $display("Test %0d: ok", num);
    end
    else
    begin
      $display("Test %0d: %0d errors", num, errorCount - errorsBefore);
    end
  endtask

  initial
  begin
    logic [31:0] r;
    logic [31:0] curTest;
    int          testStartErrors;
    dataT        got;
    logic        stalled;
    addrT        sideAddr;
    dataT        sideData;
    icEnable     = 1'b0;
    icInvalidate = 1'b0;
    pcF          = '0;
    memRead      = 1'b0;
    memWrite     = 1'b0;
    dataAdr      = '0;
    writeData    = '0;
    byteMask     = 4'hf;
    arstN        = 1'b0;
    rngState     = 32'h6c10;
    errorCount   = 0;
    checkCount   = 0;
    testCount    = 0;
    abortRun     = 1'b0;
    curTest      = '0;
    testStartErrors = 0;
    for (int i = 0; i < memWords; i++)
    begin
      shadowMem[i] = '0;
    end
    readGolden();
    if (recTest.size() == 0)
    begin
      $display("No operations were read from the golden file");
      errorCount++;
    end
    repeat (5) @(posedge clk);
    #1;
    arstN = 1'b1;

    for (int k = 0; k < recTest.size(); k++)
    begin
      if (abortRun)
      begin
        break;
      end
      if (k == 0 || recTest[k] != curTest)
      begin
        if (k > 0)
        begin
          reportTest(curTest, testStartErrors);
        end
        curTest         = recTest[k];
        testStartErrors = errorCount;
      end
      case (recOp[k])
        0:
        begin
          storeShadow(recAddr[k], recData[k], recMask[k][3:0]);
          dataAccess(1'b1, recAddr[k], recData[k], recMask[k][3:0], got);
        end
        1:
        begin
          dataAccess(1'b0, recAddr[k], '0, recMask[k][3:0], got);
          checkValue("readData", got, recExp[k]);
          checkValue("expected load vs lane rules", recExp[k],
                     expectLoad(recAddr[k], recMask[k][3:0]));
        end
        2, 5:
        begin
          r        = nextRandom();
          sideData = nextRandom();
          sideAddr = scratchBase + {r[5:2], 2'b00};
          if (!icEnable)
          begin
            settleFetch("waiting for the previous uncached fetch");
          end
          if (recOp[k] == 5 || r[0])
          begin
            fork
              fetchWord(recAddr[k], got, stalled);
              sideAccess(sideAddr, r[6], sideData, r[9:8]);
            join
          end
          else
          begin
            fetchWord(recAddr[k], got, stalled);
          end
          checkValue("instrF", got, recExp[k]);
          checkValue("iStall in first cycle", {31'b0, stalled}, {31'b0, recMask[k][0]});
          // A stalled fetch comes from memory and must match the image
          if (recMask[k][0])
          begin
            checkValue("expected fetch vs memory image", recExp[k],
                       shadowMem[(recAddr[k] >> 2) % memWords]);
          end
        end
        3:
        begin
          icEnable = recData[k][0];
          settleFetch("switching the cache mode");
        end
        4:
        begin
          icInvalidate = 1'b1;
          @(posedge clk);
          #1;
          icInvalidate = 1'b0;
        end
        default:
        begin
          $display("Unknown operation %h in the golden file", recOp[k]);
          errorCount++;
        end
      endcase
    end
    if (recTest.size() > 0)
    begin
      reportTest(curTest, testStartErrors);
    end

    $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
    if (errorCount == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/memSubsystemGolden.txt ====
# Columns, all hex: test op addr data mask expected
# op 0 store, 1 load, 2 fetch, 3 cache enable (data bit 0), 4 invalidate, 5 fetch plus data access
# For fetches, mask 1 means iStall is expected high in the first cycle, mask 0 means a hit
1 0 00000010 11223344 f 00000000
1 0 00000011 0000aa00 2 00000000
1 0 00000012 bbcc0000 c 00000000
1 1 00000010 00000000 f bbccaa44
1 1 00000011 00000000 2 000000aa
1 1 00000012 00000000 c 0000bbcc
1 1 00000010 00000000 3 0000aa44
2 0 00000040 a0000001 f 00000000
2 0 00000044 a0000002 f 00000000
2 0 00000048 a0000003 f 00000000
2 0 00000140 b0000001 f 00000000
2 2 00000044 00000000 1 a0000002
2 2 00000140 00000000 1 b0000001
3 3 00000000 00000001 0 00000000
3 2 00000040 00000000 1 a0000001
3 2 00000048 00000000 0 a0000003
3 2 0000004c 00000000 0 00000000
3 2 00000140 00000000 1 b0000001
4 0 00000140 c0000001 f 00000000
4 2 00000140 00000000 0 b0000001
4 4 00000000 00000000 0 00000000
4 2 00000140 00000000 1 c0000001
5 0 00000084 d0000002 f 00000000
5 0 0000008c d0000004 f 00000000
5 5 00000084 00000000 1 d0000002
5 2 00000080 00000000 0 00000000
5 2 0000008c 00000000 0 d0000004

// ==== files.f ====
source/memSysPkg.sv
source/instrCache.sv
source/dataPort.sv
source/busArbiter.sv
source/busMemory.sv
source/memSubsystem.sv
verif/memSubsystemTb.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - files:
      - source/memSysPkg.sv
      - source/instrCache.sv
      - source/dataPort.sv
      - source/busArbiter.sv
      - source/busMemory.sv
      - source/memSubsystem.sv
  - target: test
    files:
      - verif/memSubsystemTb.sv
